//--- Makefile
# Verilator build and run of the UMI router testbench

BIN  := obj_dir/Vtb_umi_router
SRCS := $(shell cat umi_router.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): umi_router.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_umi_router -f umi_router.f

# Fails unless the pass line is printed
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

//--- hdl/umi_addr_decode.sv
// Combinational first-match decoder on the top 16 address bits. A zero mask disables that port
`timescale 1ns/10ps

module umi_addr_decode #(
   parameter int M = 4                                  // Number of ports
) (
   input  logic [umi_pkg::UMI_AW-1:0]   dstaddr,        // Packet destination
   input  umi_pkg::region_t             regions [M],    // Base and mask per port
   output logic [M-1:0]                 select          // One-hot or zero
);

   import umi_pkg::*;

   logic [REGION_W-1:0] upper;                          // Decoded address bits
   logic [M-1:0]        hit;                            // Raw region matches

   assign upper = dstaddr[UMI_AW-1 -: REGION_W];

   // Match every region in parallel
   always_comb begin
      for (int i = 0; i < M; i++) begin
         hit[i] = (regions[i].mask != '0) &&
                  (((upper ^ regions[i].base) & regions[i].mask) == '0);
      end
   end

   // Keep the lowest set bit only
   // Overlapping regions resolve to the lower port
   always_comb begin
      select = hit & (~hit + 1'b1);                     // Isolate lowest hit
   end

endmodule

//--- hdl/umi_demux.sv
// Broadcast demux for any payload type. A zero select reports ready and no port takes the packet
`timescale 1ns/10ps

module umi_demux #(
   parameter int  M = 4,                               // Number of outputs
   parameter type T = logic                            // Payload type
) (
   // Port selector
   input  logic [M-1:0] select,
   // Incoming stream
   input  logic         in_valid,
   input  T             in_pkt,
   output logic         in_ready,
   // Outgoing streams
   output logic [M-1:0] out_valid,
   output T             out_pkt [M],
   input  logic [M-1:0] out_ready
);

   // Valid only towards the selected port
   assign out_valid = {M{in_valid}} & select;

   // Unselected ports never hold back the input
   assign in_ready = &(~select | out_ready);

   // Same payload on every port
   for (genvar i = 0; i < M; i++) begin : g_bcast
      assign out_pkt[i] = in_pkt;
   end

endmodule

//--- hdl/umi_map_regs.sv
// Region table and drop counter. M must not exceed 8 and reads of unmapped indices return zero
`timescale 1ns/10ps

module umi_map_regs #(
   parameter int M = 4                                  // Number of ports
) (
   input  logic                         clk,
   input  logic                         arst_n,
   // Configuration strobes
   input  logic                         cfg_write,
   input  logic [umi_pkg::CFG_AW-1:0]   cfg_addr,
   input  logic [umi_pkg::CFG_DW-1:0]   cfg_wdata,
   output logic [umi_pkg::CFG_DW-1:0]   cfg_rdata,
   // Dropped packet pulse
   input  logic                         drop,
   // Region table to the decoder
   output umi_pkg::region_t             regions [M]
);

   import umi_pkg::*;

   logic [CFG_DW-1:0] drop_cnt;                         // Saturating drop count

   // Table and counter writes
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < M; i++) begin
            regions[i] <= '0;                           // Mask zero disables port
         end
         drop_cnt <= '0;
      end else begin
         for (int i = 0; i < M; i++) begin
            if (cfg_write && cfg_addr == CFG_AW'(REG_BASE_OFS + i))
               regions[i].base <= cfg_wdata;
            if (cfg_write && cfg_addr == CFG_AW'(REG_MASK_OFS + i))
               regions[i].mask <= cfg_wdata;
         end
         if (cfg_write && cfg_addr == CFG_AW'(REG_DROP))
            drop_cnt <= '0;                             // Clear wins over a drop
         else if (drop && drop_cnt != '1)
            drop_cnt <= drop_cnt + 1'b1;                // Stick at all ones
      end
   end

   // Read-back mux
   always_comb begin
      cfg_rdata = '0;                                   // Unmapped index
      for (int i = 0; i < M; i++) begin
         if (cfg_addr == CFG_AW'(REG_BASE_OFS + i))
            cfg_rdata = regions[i].base;
         if (cfg_addr == CFG_AW'(REG_MASK_OFS + i))
            cfg_rdata = regions[i].mask;
      end
      if (cfg_addr == CFG_AW'(REG_DROP))
         cfg_rdata = drop_cnt;
   end

   // Write index must be resolved on every strobe
   a_cfg_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
      cfg_write |-> !$isunknown(cfg_addr))
      else $error("cfg_write with unknown cfg_addr %h", cfg_addr);

endmodule

//--- hdl/umi_pkg.sv
// UMI widths and register map shared by all blocks. Data width is fixed at 64 and the map holds at most 8 ports

package umi_pkg;

   // UMI field widths
   localparam int UMI_CW   = 32;         // Command
   localparam int UMI_AW   = 64;         // Source and destination address
   localparam int UMI_DW   = 64;         // Data payload

   // Upper address bits seen by the decoder
   localparam int REGION_W = 16;

   // Configuration port
   localparam int CFG_AW   = 5;          // Register index
   localparam int CFG_DW   = 16;         // Register data

   // Register indices
   localparam int REG_BASE_OFS = 0;      // Base of port i at index i
   localparam int REG_MASK_OFS = 8;      // Mask of port i at index 8+i
   localparam int REG_DROP     = 16;     // Drop counter, write clears

   // Full request packet, 224 bits
   typedef struct packed {
      logic [UMI_CW-1:0] cmd;
      logic [UMI_AW-1:0] dstaddr;
      logic [UMI_AW-1:0] srcaddr;
      logic [UMI_DW-1:0] data;
   } umi_pkt_t;

   // One region table entry
   typedef struct packed {
      logic [REGION_W-1:0] base;          // Compared upper address
      logic [REGION_W-1:0] mask;          // 1 = bit must match
   } region_t;

endpackage

//--- hdl/umi_port_fifo.sv
// Synchronous valid/ready FIFO. DEPTH must be a power of two of at least 2 and T a packed type
`timescale 1ns/10ps

module umi_port_fifo #(
   parameter int  DEPTH = 4,                           // Entries
   parameter type T     = logic                        // Payload type
) (
   input  logic clk,
   input  logic arst_n,
   // Write side
   input  logic in_valid,
   input  T     in_data,
   output logic in_ready,                              // Not full
   // Read side
   output logic out_valid,                             // Not empty
   output T     out_data,
   input  logic out_ready
);

   localparam int AW = $clog2(DEPTH);                  // Index width

   T            mem [DEPTH];                           // Payload storage
   logic [AW:0] wr_ptr;                                // Extra bit is the wrap flag
   logic [AW:0] rd_ptr;
   logic        full;
   logic        empty;
   logic        wr_en;
   logic        rd_en;

   // Same index and flags differ means full
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                  (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   assign in_ready  = ~full;
   assign out_valid = ~empty;
   assign wr_en     = in_valid & in_ready;             // Accepted write
   assign rd_en     = out_valid & out_ready;           // Accepted read

   // Head entry, shows one cycle after the write
   assign out_data = mem[rd_ptr[AW-1:0]];

   // Pointers
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;                   // Same cycle as a write is fine
      end
   end

   // Storage
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr[AW-1:0]] <= in_data;
      end
   end

   // A write past full or a read past empty pushes the count beyond DEPTH
   a_occupancy: assert property (@(posedge clk) disable iff (!arst_n)
      (AW+1)'(wr_ptr - rd_ptr) <= DEPTH)
      else $error("FIFO occupancy %0d beyond depth", (AW+1)'(wr_ptr - rd_ptr));

   // Stalled head must hold until taken
   a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
      else $error("FIFO head changed under back-pressure");

endmodule

//--- hdl/umi_router.sv
// UMI request router to M ports. No responses or multicast and unmatched packets are dropped and counted
`timescale 1ns/10ps

module umi_router #(
   parameter int M     = 4,                            // Output ports, 8 at most
   parameter int DEPTH = 4                             // FIFO entries per port
) (
   input  logic                         clk,
   input  logic                         arst_n,
   // UMI request input
   input  logic                         umi_in_valid,
   input  umi_pkg::umi_pkt_t            umi_in_pkt,
   output logic                         umi_in_ready,
   // UMI request outputs
   output logic [M-1:0]                 umi_out_valid,
   output umi_pkg::umi_pkt_t            umi_out_pkt [M],
   input  logic [M-1:0]                 umi_out_ready,
   // Configuration port
   input  logic                         cfg_write,
   input  logic [umi_pkg::CFG_AW-1:0]   cfg_addr,
   input  logic [umi_pkg::CFG_DW-1:0]   cfg_wdata,
   output logic [umi_pkg::CFG_DW-1:0]   cfg_rdata
);

   import umi_pkg::*;

   region_t      regions [M];                          // Table to decoder
   logic [M-1:0] select;                               // Decoded port
   logic [M-1:0] fifo_valid;                           // Demux to FIFO
   umi_pkt_t     fifo_pkt [M];
   logic [M-1:0] fifo_ready;                           // FIFO not full
   logic         drop;

   // Accepted with no matching region
   assign drop = umi_in_valid & umi_in_ready & ~|select;

   umi_map_regs #(.M(M)) umi_map_regs_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .cfg_write (cfg_write),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .drop      (drop),
      .regions   (regions)
   );

   umi_addr_decode #(.M(M)) umi_addr_decode_inst (
      .dstaddr (umi_in_pkt.dstaddr),
      .regions (regions),
      .select  (select)
   );

   umi_demux #(.M(M), .T(umi_pkt_t)) umi_demux_inst (
      .select    (select),
      .in_valid  (umi_in_valid),
      .in_pkt    (umi_in_pkt),
      .in_ready  (umi_in_ready),
      .out_valid (fifo_valid),
      .out_pkt   (fifo_pkt),
      .out_ready (fifo_ready)
   );

   // One buffer per port so a stalled port leaves the others running
   for (genvar i = 0; i < M; i++) begin : g_port
      umi_port_fifo #(.DEPTH(DEPTH), .T(umi_pkt_t)) umi_port_fifo_inst (
         .clk       (clk),
         .arst_n    (arst_n),
         .in_valid  (fifo_valid[i]),
         .in_data   (fifo_pkt[i]),
         .in_ready  (fifo_ready[i]),
         .out_valid (umi_out_valid[i]),
         .out_data  (umi_out_pkt[i]),
         .out_ready (umi_out_ready[i])
      );
   end

   // Source must hold a stalled request
   a_in_hold: assert property (@(posedge clk) disable iff (!arst_n)
      umi_in_valid && !umi_in_ready |=> umi_in_valid && $stable(umi_in_pkt))
      else $error("UMI input changed before transfer");

endmodule

//--- tb/tb_umi_router.sv
// Testbench for umi_router at M=4 and DEPTH=4. Config writes are made only while no traffic flows
`timescale 1ns/10ps

module tb_umi_router;

   import umi_pkg::*;

   localparam int M     = 4;
   localparam int DEPTH = 4;
   localparam int TMO   = 200;                         // Cycles per wait
   localparam logic [31:0] SEED = 32'hbe9c_0e0d;

   logic              clk;
   logic              arst_n;
   logic              umi_in_valid;
   umi_pkt_t          umi_in_pkt;
   logic              umi_in_ready;
   logic [M-1:0]      umi_out_valid;
   umi_pkt_t          umi_out_pkt [M];
   logic [M-1:0]      umi_out_ready = '1;
   logic              cfg_write;
   logic [CFG_AW-1:0] cfg_addr;
   logic [CFG_DW-1:0] cfg_wdata;
   logic [CFG_DW-1:0] cfg_rdata;

   logic [31:0]       stim_lfsr = SEED;                // Packet fields and targets
   logic [31:0]       rdy_lfsr  = SEED;                // Output ready pattern
   logic              rdy_rand;
   logic [M-1:0]      rdy_hold;                        // Ready when not random
   logic [15:0]       base_m [M];                      // Region table copy
   logic [15:0]       mask_m [M];
   umi_pkt_t          exp_q [M][$];                    // Per-port scoreboard
   umi_pkt_t          exp_head [M];
   int                exp_size [M];
   int                exp_port;                        // -1 when unmatched
   int                drops_total;
   int                drops_base;                      // Count at last clear
   logic              rd_check;
   logic [CFG_DW-1:0] exp_rdata;
   int                errors;
   int                timeouts;

   umi_router #(.M(M), .DEPTH(DEPTH)) umi_router_inst (.*);

   always #5 clk = ~clk;

   // Taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [63:0] stim_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         stim_lfsr = lfsr_step(stim_lfsr);
         v = {v[62:0], stim_lfsr[0]};                  // One step per bit
      end
      return v;
   endfunction

   // Kind 0 hits ports 0 and 1, kinds 6 and 7 hit nothing, -1 picks at random
   function automatic umi_pkt_t make_pkt(input int kind);
      umi_pkt_t    p;
      logic [15:0] r;
      logic [15:0] upper;
      int          k;
      k = kind;
      if (kind < 0)
         k = int'(stim_bits(3));
      r = 16'(stim_bits(16));
      case (k)
         0:       upper = {8'h10, r[7:0]};
         1:       upper = {8'h1f, r[7:0]};
         2:       upper = 16'h2000;
         3, 5:    upper = {2'b01, r[13:0]};
         4:       upper = {8'h18, r[7:0]};
         default: upper = {1'b1, r[14:0]};
      endcase
      p.cmd     = 32'(stim_bits(32));
      p.dstaddr = {upper, 48'(stim_bits(48))};
      p.srcaddr = stim_bits(64);
      p.data    = stim_bits(64);
      return p;
   endfunction

   function automatic logic [CFG_DW-1:0] model_read(input int idx);
      if (idx >= REG_BASE_OFS && idx < REG_BASE_OFS + M) return base_m[idx - REG_BASE_OFS];
      if (idx >= REG_MASK_OFS && idx < REG_MASK_OFS + M) return mask_m[idx - REG_MASK_OFS];
      if (idx == REG_DROP) return CFG_DW'(drops_total - drops_base);
      return '0;
   endfunction

   // Expected port by first match, lowest index wins
   always_comb begin
      exp_port = -1;
      for (int i = M - 1; i >= 0; i--)
         if (mask_m[i] != '0 && (umi_in_pkt.dstaddr[63:48] & mask_m[i]) == (base_m[i] & mask_m[i]))
            exp_port = i;
   end

   // Two bits per port, ready three cycles in four
   always @(posedge clk) begin
      logic [M-1:0] r;
      logic         a;
      for (int i = 0; i < M; i++) begin
         rdy_lfsr = lfsr_step(rdy_lfsr);
         a = rdy_lfsr[0];
         rdy_lfsr = lfsr_step(rdy_lfsr);
         r[i] = a | rdy_lfsr[0];
      end
      umi_out_ready <= rdy_rand ? r : rdy_hold;
   end

   // Scoreboard, pops before pushes
   always @(posedge clk) begin
      if (arst_n) begin
         for (int i = 0; i < M; i++)
            if (umi_out_valid[i] && umi_out_ready[i] && exp_q[i].size() > 0)
               void'(exp_q[i].pop_front());
         if (umi_in_valid && umi_in_ready) begin
            if (exp_port < 0)
               drops_total++;
            else
               exp_q[exp_port].push_back(umi_in_pkt);
         end
         for (int i = 0; i < M; i++) begin
            exp_size[i] = exp_q[i].size();
            exp_head[i] = (exp_size[i] > 0) ? exp_q[i][0] : '0;
         end
      end
   end

   for (genvar i = 0; i < M; i++) begin : g_port_chk
      a_pkt: assert property (@(posedge clk) disable iff (!arst_n)
         umi_out_valid[i] && umi_out_ready[i] |-> umi_out_pkt[i] == exp_head[i])
         else begin
            errors++;
            $display("ERR %0t umi_out_pkt[%0d] got %h exp %h", $time, i,
                     $sampled(umi_out_pkt[i]), $sampled(exp_head[i]));
         end
      a_no_extra: assert property (@(posedge clk) disable iff (!arst_n)
         umi_out_valid[i] |-> exp_size[i] != 0)    // Catches drops and wrong ports
         else begin
            errors++;
            $display("ERR %0t umi_out_valid[%0d] got 1 exp 0", $time, i);
         end
      a_latency: assert property (@(posedge clk) disable iff (!arst_n)
         umi_in_valid && umi_in_ready && exp_port == i && exp_size[i] == 0 |=> umi_out_valid[i])
         else begin
            errors++;
            $display("ERR %0t umi_out_valid[%0d] got 0 exp 1", $time, i);
         end
      a_backpress: assert property (@(posedge clk) disable iff (!arst_n)
         umi_in_valid && exp_port == i |-> umi_in_ready == (exp_size[i] < DEPTH))
         else begin
            errors++;
            $display("ERR %0t umi_in_ready got %b exp %b", $time, $sampled(umi_in_ready),
                     $sampled(exp_size[i] < DEPTH));
         end
   end

   a_drop_ready: assert property (@(posedge clk) disable iff (!arst_n)
      umi_in_valid && exp_port < 0 |-> umi_in_ready)
      else begin
         errors++;
         $display("ERR %0t umi_in_ready got 0 exp 1", $time);
      end

   a_rdata: assert property (@(posedge clk) disable iff (!arst_n)
      rd_check |-> cfg_rdata == exp_rdata)
      else begin
         errors++;
         $display("ERR %0t cfg_rdata[%0d] got %h exp %h", $time, $sampled(cfg_addr),
                  $sampled(cfg_rdata), $sampled(exp_rdata));
      end

   task automatic end_run();
      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   endtask

   task automatic timed_out(input string what);
      timeouts++;
      $display("Timeout while waiting for %s", what);
      end_run();
   endtask

   // Callers sit on a rising edge
   task automatic check_reg(input int idx);
      cfg_addr  <= CFG_AW'(idx);
      exp_rdata <= model_read(idx);
      rd_check  <= 1'b1;
      @(posedge clk);                                  // Assertion samples here
      rd_check  <= 1'b0;
   endtask

   task automatic write_reg(input int idx, input logic [15:0] v);
      cfg_write <= 1'b1;
      cfg_addr  <= CFG_AW'(idx);
      cfg_wdata <= v;
      if (idx >= REG_BASE_OFS && idx < REG_BASE_OFS + M) base_m[idx - REG_BASE_OFS] = v;
      if (idx >= REG_MASK_OFS && idx < REG_MASK_OFS + M) mask_m[idx - REG_MASK_OFS] = v;
      if (idx == REG_DROP) drops_base = drops_total;
      @(posedge clk);
      cfg_write <= 1'b0;
      check_reg(idx);                                  // Visible one cycle after strobe
   endtask

   task automatic send_pkt(input umi_pkt_t p);
      int n;
      umi_in_valid <= 1'b1;
      umi_in_pkt   <= p;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!umi_in_ready && n < TMO);            // Pre-edge ready
      umi_in_valid <= 1'b0;
      if (!umi_in_ready)
         timed_out("input handshake");
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      @(posedge clk);
      while ((exp_size[0] + exp_size[1] + exp_size[2] + exp_size[3]) != 0 && n < TMO) begin
         @(posedge clk);
         n++;
      end
      if ((exp_size[0] + exp_size[1] + exp_size[2] + exp_size[3]) != 0)
         timed_out("output ports to drain");
   endtask

   initial begin
      clk = 1'b0;
      arst_n = 1'b0;
      umi_in_valid = 1'b0;
      umi_in_pkt = '0;
      cfg_write = 1'b0;
      cfg_addr = '0;
      cfg_wdata = '0;
      rd_check = 1'b0;
      exp_rdata = '0;
      rdy_rand = 1'b0;
      rdy_hold = '1;
      drops_total = 0;
      drops_base = 0;
      errors = 0;
      timeouts = 0;
      for (int i = 0; i < M; i++) begin
         base_m[i] = '0;
         mask_m[i] = '0;
         exp_size[i] = 0;
         exp_head[i] = '0;
      end
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < M; i++) begin
         check_reg(REG_BASE_OFS + i);                  // All zero after reset
         check_reg(REG_MASK_OFS + i);
      end
      check_reg(REG_DROP);
      // Ports 0 and 1 overlap on 0x10xx
      write_reg(REG_BASE_OFS + 0, 16'h1000);
      write_reg(REG_MASK_OFS + 0, 16'hff00);
      write_reg(REG_BASE_OFS + 1, 16'h1000);
      write_reg(REG_MASK_OFS + 1, 16'hf000);
      write_reg(REG_BASE_OFS + 2, 16'h2000);
      write_reg(REG_MASK_OFS + 2, 16'hffff);
      write_reg(REG_BASE_OFS + 3, 16'h4000);
      write_reg(REG_MASK_OFS + 3, 16'hc000);
      rdy_rand <= 1'b1;
      repeat (300) send_pkt(make_pkt(-1));
      rdy_rand <= 1'b0;
      rdy_hold <= '1;
      wait_drained();
      check_reg(REG_DROP);
      write_reg(REG_DROP, 16'h0);                      // Clears the counter
      // Port 2 stalled, others keep going
      rdy_hold <= 4'b1011;
      repeat (DEPTH) send_pkt(make_pkt(2));
      send_pkt(make_pkt(0));
      send_pkt(make_pkt(3));
      send_pkt(make_pkt(6));
      fork
         send_pkt(make_pkt(2));                        // Stalls until release
         begin
            repeat (10) @(posedge clk);
            rdy_hold <= '1;
         end
      join
      wait_drained();
      check_reg(REG_DROP);
      end_run();
   end

endmodule

//--- umi_router.f
hdl/umi_pkg.sv
hdl/umi_map_regs.sv
hdl/umi_addr_decode.sv
hdl/umi_demux.sv
hdl/umi_port_fifo.sv
hdl/umi_router.sv
tb/tb_umi_router.sv
